//--- include/dmr_settings.svh
// Build-time constants for the dual-core lockstep subsystem
// Included by the package and by every RTL file that needs a width, an address or an option
`ifndef DMR_SETTINGS_SVH
`define DMR_SETTINGS_SVH

// Accumulator and operand width
`define DMR_DATA_W 16

// Configuration bus register map
`define DMR_ADDR_CTRL     2'd0
`define DMR_ADDR_STATUS   2'd1
`define DMR_ADDR_MISMATCH 2'd2

// 1 locks the pair in DMR for good, 0 keeps the rollback path out of the build
`define DMR_FIXED          0
`define DMR_RAPID_RECOVERY 1

`endif

//--- source/dmr_pkg.sv
// Shared types for the lockstep subsystem
// Imported by the RTL and the testbench for modes, opcodes and bus payloads
`include "dmr_settings.svh"

package dmr_pkg;

  // Redundancy controller state
  typedef enum logic [1:0] {NON_DMR, DMR_RUN, DMR_RESTORE} dmr_mode_e;

  // Accumulator operations
  typedef enum logic [1:0] {OP_ADD, OP_XOR, OP_CLR} op_code_e;

  // One operation, core_id only steers in independent mode
  typedef struct packed {
    op_code_e                op;
    logic                    core_id;
    logic [`DMR_DATA_W-1:0]  operand;
  } op_req_t;

  // One result as seen on the shared result bus
  typedef struct packed {
    logic                    core_id;
    logic [`DMR_DATA_W-1:0]  acc;
    logic                    mismatch;
  } core_res_t;

  // Configuration bus payloads
  typedef struct packed {
    logic        write;
    logic [1:0]  addr;
    logic [15:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic [15:0] rdata;
  } cfg_rsp_t;

  // Control bits exported to the hardware
  typedef struct packed {
    logic enable;
    logic rapid_recovery;
    logic force_recovery;
  } dmr_cfg_t;

endpackage

//--- source/dmr_cfg_regs.sv
// Configuration registers for the lockstep subsystem
// Always-ready valid/ready bus with combinational read data,
// plus hardware pulses that clear force, set resynch and count mismatches
`timescale 1ns/1ns
`include "dmr_settings.svh"

module dmr_cfg_regs import dmr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      cfg_valid_i,
  input  cfg_req_t  cfg_req_i,
  output logic      cfg_ready_o,
  output cfg_rsp_t  cfg_rsp_o,
  input  logic      force_clr_i,
  input  logic      resynch_set_i,
  input  logic      mismatch_incr_i,
  input  dmr_mode_e mode_i,
  output dmr_cfg_t  cfg_o
);

  logic        enable_q, rapid_q, force_q, resynch_q;
  logic [15:0] mismatch_q;
  logic        wr_ctrl, wr_status;

  // Every request completes in the cycle it is presented
  assign cfg_ready_o = 1'b1;
  assign wr_ctrl   = cfg_valid_i && cfg_ready_o && cfg_req_i.write &&
                     (cfg_req_i.addr == `DMR_ADDR_CTRL);
  assign wr_status = cfg_valid_i && cfg_ready_o && cfg_req_i.write &&
                     (cfg_req_i.addr == `DMR_ADDR_STATUS);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q   <= 1'b0;
      rapid_q    <= 1'b0;
      force_q    <= 1'b0;
      resynch_q  <= 1'b0;
      mismatch_q <= '0;
    end else begin
      if (wr_ctrl) begin
        enable_q <= cfg_req_i.wdata[0];
        // Stuck at 0 when the rollback path is not built
        rapid_q  <= cfg_req_i.wdata[1] && (`DMR_RAPID_RECOVERY != 0);
      end
      // Controller taking the request beats a same-cycle write
      if (force_clr_i) begin
        force_q <= 1'b0;
      end else if (wr_ctrl) begin
        force_q <= cfg_req_i.wdata[2];
      end
      // Sticky flag, write 1 to clear
      if (resynch_set_i) begin
        resynch_q <= 1'b1;
      end else if (wr_status && cfg_req_i.wdata[2]) begin
        resynch_q <= 1'b0;
      end
      // Saturating count of mismatches left to software
      if (mismatch_incr_i && (mismatch_q != '1)) begin
        mismatch_q <= mismatch_q + 16'd1;
      end
    end
  end

  // Read mux
  always_comb begin
    cfg_rsp_o.rdata = '0;
    case (cfg_req_i.addr)
      `DMR_ADDR_CTRL:     cfg_rsp_o.rdata = {13'd0, force_q, rapid_q, enable_q};
      `DMR_ADDR_STATUS:   cfg_rsp_o.rdata = {13'd0, resynch_q, mode_i};
      `DMR_ADDR_MISMATCH: cfg_rsp_o.rdata = mismatch_q;
      default:            cfg_rsp_o.rdata = '0;
    endcase
  end

  assign cfg_o = '{enable: enable_q, rapid_recovery: rapid_q, force_recovery: force_q};

endmodule

//--- source/dmr_ctrl.sv
// Redundancy mode controller
// Moves the core pair between independent, lockstep and restore states,
// and issues the rollback, setback and software notification pulses
`timescale 1ns/1ns
`include "dmr_settings.svh"

module dmr_ctrl import dmr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  dmr_cfg_t  cfg_i,
  input  logic      fetch_en_i,
  input  logic      dmr_error_i,
  input  logic      cores_synch_i,
  input  logic      recovery_finished_i,
  output dmr_mode_e mode_o,
  output logic      recovery_req_o,
  output logic      sw_synch_req_o,
  output logic      sw_resynch_req_o,
  output logic      mismatch_incr_o,
  output logic      force_clr_o
);

  dmr_mode_e mode_d, mode_q;
  logic      rr_en;

  // Rollback only when enabled in the register and present in the build
  assign rr_en  = cfg_i.rapid_recovery && (`DMR_RAPID_RECOVERY != 0);
  assign mode_o = mode_q;

  always_comb begin
    mode_d           = mode_q;
    recovery_req_o   = 1'b0;
    sw_synch_req_o   = 1'b0;
    sw_resynch_req_o = 1'b0;
    mismatch_incr_o  = 1'b0;
    force_clr_o      = 1'b0;

    case (mode_q)
      DMR_RUN: begin
        // Software asked for a rollback
        if (cfg_i.force_recovery && rr_en) begin
          force_clr_o = 1'b1;
          mode_d      = DMR_RESTORE;
        end
        if (dmr_error_i) begin
          if (rr_en) begin
            mode_d = DMR_RESTORE;
          end else begin
            // No rollback so software is told
            sw_resynch_req_o = 1'b1;
            mismatch_incr_o  = 1'b1;
          end
        end
      end
      DMR_RESTORE: begin
        // Held until the checkpoint is back in both cores
        recovery_req_o = 1'b1;
        if (recovery_finished_i) begin
          mode_d = DMR_RUN;
        end
      end
      default: begin
        mode_d = mode_q;
      end
    endcase

    // Mode switching is absent in a fixed lockstep build
    if (`DMR_FIXED == 0) begin
      // Before fetch starts the enable bit alone picks the mode
      if (!fetch_en_i) begin
        mode_d = cfg_i.enable ? DMR_RUN : NON_DMR;
      end
      // Splitting is always allowed
      if (mode_q == DMR_RUN && !cfg_i.enable) begin
        mode_d = NON_DMR;
      end
      // Joining needs core 1 set back to core 0 first
      if (mode_q == NON_DMR && cfg_i.enable) begin
        sw_synch_req_o = 1'b1;
        if (cores_synch_i) begin
          mode_d = DMR_RUN;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q <= (`DMR_FIXED != 0) ? DMR_RUN : NON_DMR;
    end else begin
      mode_q <= mode_d;
    end
  end

  // Restore lasts one cycle since the comparator loads both cores at once
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    recovery_req_o |-> (mode_o == DMR_RESTORE) && recovery_finished_i);

endmodule

//--- source/accum_core.sv
// Accumulator core standing in for one processor of the pair
// One op per handshake, result held in a one-entry slot until popped;
// the load port overwrites the state for rollback and setback
`timescale 1ns/1ns
`include "dmr_settings.svh"

module accum_core import dmr_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   op_valid_i,
  input  op_req_t                op_i,
  output logic                   op_ready_o,
  output logic                   res_valid_o,
  output core_res_t              res_o,
  input  logic                   res_ready_i,
  input  logic                   load_en_i,
  input  logic [`DMR_DATA_W-1:0] load_val_i,
  output logic [`DMR_DATA_W-1:0] acc_o,
  input  logic                   fault_i
);

  logic [`DMR_DATA_W-1:0] acc_q, acc_in, acc_new;
  logic                   valid_q, accept;
  core_res_t              slot_q;

  // Free slot, or the held result leaves this cycle
  assign op_ready_o = !valid_q || res_ready_i;
  assign accept     = op_valid_i && op_ready_o;

  // Injected upset on bit 0
  assign acc_in = acc_q ^ {{(`DMR_DATA_W-1){1'b0}}, fault_i};

  always_comb begin
    case (op_i.op)
      OP_ADD:  acc_new = acc_in + op_i.operand;
      OP_XOR:  acc_new = acc_in ^ op_i.operand;
      default: acc_new = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q   <= '0;
      valid_q <= 1'b0;
    end else if (load_en_i) begin
      // State load also discards any held result
      acc_q   <= load_val_i;
      valid_q <= 1'b0;
    end else begin
      acc_q <= accept ? acc_new : acc_in;
      if (accept) begin
        valid_q <= 1'b1;
      end else if (res_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  // Result payload
  always_ff @(posedge clk_i) begin
    if (accept && !load_en_i) begin
      slot_q <= '{core_id: op_i.core_id, acc: acc_new, mismatch: 1'b0};
    end
  end

  assign res_valid_o = valid_q;
  assign res_o       = slot_q;
  assign acc_o       = acc_q;

  // Held result is stable until popped or flushed by a load
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o && !res_ready_i && !load_en_i |=> res_valid_o && $stable(res_o));

endmodule

//--- source/dmr_compare_recover.sv
// Lockstep result comparator and state-load sequencer
// Flags a differing result pair once, tracks the last agreed accumulator,
// and drives the core load ports for rollback and core 1 setback
`timescale 1ns/1ns
`include "dmr_settings.svh"

module dmr_compare_recover import dmr_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  dmr_mode_e              mode_i,
  input  logic                   res0_valid_i,
  input  logic                   res1_valid_i,
  input  core_res_t              res0_i,
  input  core_res_t              res1_i,
  input  logic                   pop_i,
  input  logic [`DMR_DATA_W-1:0] acc0_i,
  input  logic                   recovery_req_i,
  input  logic                   sw_synch_req_i,
  output logic                   dmr_error_o,
  output logic                   cores_synch_o,
  output logic                   recovery_finished_o,
  output logic                   load0_o,
  output logic                   load1_o,
  output logic [`DMR_DATA_W-1:0] load_val_o
);

  logic [`DMR_DATA_W-1:0] ckpt_q;
  logic                   pair_valid, differ, err_seen_q, setback, synch_q;

  assign pair_valid = (mode_i == DMR_RUN) && res0_valid_i && res1_valid_i;
  assign differ     = pair_valid && (res0_i.acc != res1_i.acc);
  // One error pulse per pair, even when it waits on back-pressure
  assign dmr_error_o = differ && !err_seen_q;

  // Setback waits for both slots to drain so no result is flushed
  assign setback = sw_synch_req_i && !res0_valid_i && !res1_valid_i;

  // Rollback loads both cores and completes in the same cycle
  assign load0_o             = recovery_req_i;
  assign load1_o             = recovery_req_i || setback;
  assign load_val_o          = recovery_req_i ? ckpt_q : acc0_i;
  assign recovery_finished_o = recovery_req_i;

  // Accumulators are equal the cycle after core 1 took core 0's value
  assign cores_synch_o = synch_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ckpt_q     <= '0;
      err_seen_q <= 1'b0;
      synch_q    <= 1'b0;
    end else begin
      err_seen_q <= differ && !pop_i;
      synch_q    <= setback;
      // Checkpoint follows core 0 alone, or agreed pairs in lockstep
      if (mode_i == NON_DMR) begin
        ckpt_q <= acc0_i;
      end else if (pair_valid && pop_i && !differ) begin
        ckpt_q <= res0_i.acc;
      end
    end
  end

endmodule

//--- source/result_arbiter.sv
// Merges the two core result channels onto the shared result bus
// Round-robin in independent mode; in lockstep the pair is popped together
// and core 0 is forwarded, or the pair is dropped for a rollback
`timescale 1ns/1ns

module result_arbiter import dmr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  dmr_mode_e mode_i,
  input  logic      error_drop_i,
  input  logic      in0_valid_i,
  input  logic      in1_valid_i,
  input  core_res_t in0_i,
  input  core_res_t in1_i,
  output logic      in0_ready_o,
  output logic      in1_ready_o,
  output logic      out_valid_o,
  output core_res_t out_o,
  input  logic      out_ready_i
);

  logic rr_q, lockstep, both_valid, grant1;

  assign lockstep   = (mode_i != NON_DMR);
  assign both_valid = in0_valid_i && in1_valid_i;
  // Core 1 wins when alone or when the pointer favours it
  assign grant1     = in1_valid_i && (!in0_valid_i || rr_q);

  always_comb begin
    out_o          = in0_i;
    out_o.core_id  = 1'b0;
    out_o.mismatch = 1'b0;
    if (lockstep) begin
      // Dropped pairs leave without waiting for the consumer
      out_valid_o    = both_valid && !error_drop_i;
      out_o.mismatch = (in0_i.acc != in1_i.acc);
      in0_ready_o    = both_valid && (out_ready_i || error_drop_i);
      in1_ready_o    = both_valid && (out_ready_i || error_drop_i);
    end else begin
      out_valid_o = in0_valid_i || in1_valid_i;
      if (grant1) begin
        out_o         = in1_i;
        out_o.core_id = 1'b1;
      end
      in0_ready_o = out_ready_i && in0_valid_i && !grant1;
      in1_ready_o = out_ready_i && grant1;
    end
  end

  // Priority passes to the other core after each independent transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= 1'b0;
    end else if (!lockstep && out_valid_o && out_ready_i) begin
      rr_q <= !grant1;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !lockstep |-> $onehot0({in0_ready_o, in1_ready_o}));

endmodule

//--- source/dmr_lockstep.sv
// Top of the dual-core lockstep subsystem
// Connects config registers, mode controller, both cores, comparator and arbiter;
// steers incoming ops to one core or both depending on the mode
`timescale 1ns/1ns
`include "dmr_settings.svh"

module dmr_lockstep import dmr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      fetch_en_i,
  input  logic      fault_inject_i,
  input  logic      cfg_valid_i,
  input  cfg_req_t  cfg_req_i,
  output logic      cfg_ready_o,
  output cfg_rsp_t  cfg_rsp_o,
  input  logic      op_valid_i,
  input  op_req_t   op_req_i,
  output logic      op_ready_o,
  output logic      res_valid_o,
  output core_res_t res_o,
  input  logic      res_ready_i
);

  dmr_cfg_t               cfg;
  dmr_mode_e              mode;
  logic                   lockstep, hold_ops, error_drop;
  logic                   recovery_req, recovery_fin, sw_synch_req, sw_resynch_req;
  logic                   mismatch_incr, force_clr, dmr_error, cores_synch;
  logic                   op0_valid, op1_valid, op0_ready, op1_ready;
  logic                   res0_valid, res1_valid, res0_ready, res1_ready;
  core_res_t              res0, res1;
  logic                   load0, load1;
  logic [`DMR_DATA_W-1:0] load_val, acc0;

  assign lockstep   = (mode != NON_DMR);
  // Mismatch that is rolled back, the pair never reaches the bus
  assign error_drop = dmr_error && cfg.rapid_recovery;

  // Stall ops while a state load is pending or under way
  assign hold_ops = !fetch_en_i || (mode == DMR_RESTORE) || sw_synch_req || error_drop ||
                    ((mode == DMR_RUN) && cfg.force_recovery && cfg.rapid_recovery);

  assign op_ready_o = !hold_ops &&
                      (lockstep ? (op0_ready && op1_ready)
                                : (op_req_i.core_id ? op1_ready : op0_ready));
  assign op0_valid  = op_valid_i && op_ready_o && (lockstep || !op_req_i.core_id);
  assign op1_valid  = op_valid_i && op_ready_o && (lockstep || op_req_i.core_id);

  dmr_cfg_regs i_cfg_regs (
    .clk_i, .rst_ni, .cfg_valid_i, .cfg_req_i, .cfg_ready_o, .cfg_rsp_o,
    .force_clr_i(force_clr), .resynch_set_i(sw_resynch_req),
    .mismatch_incr_i(mismatch_incr), .mode_i(mode), .cfg_o(cfg)
  );

  dmr_ctrl i_ctrl (
    .clk_i, .rst_ni, .cfg_i(cfg), .fetch_en_i, .dmr_error_i(dmr_error),
    .cores_synch_i(cores_synch), .recovery_finished_i(recovery_fin), .mode_o(mode),
    .recovery_req_o(recovery_req), .sw_synch_req_o(sw_synch_req),
    .sw_resynch_req_o(sw_resynch_req), .mismatch_incr_o(mismatch_incr),
    .force_clr_o(force_clr)
  );

  // Core 0 is the reference copy, faults are injected into core 1
  accum_core i_core0 (
    .clk_i, .rst_ni, .op_valid_i(op0_valid), .op_i(op_req_i), .op_ready_o(op0_ready),
    .res_valid_o(res0_valid), .res_o(res0), .res_ready_i(res0_ready),
    .load_en_i(load0), .load_val_i(load_val), .acc_o(acc0), .fault_i(1'b0)
  );

  // Core 1 state is only observed through its results
  accum_core i_core1 (
    .clk_i, .rst_ni, .op_valid_i(op1_valid), .op_i(op_req_i), .op_ready_o(op1_ready),
    .res_valid_o(res1_valid), .res_o(res1), .res_ready_i(res1_ready),
    .load_en_i(load1), .load_val_i(load_val), .acc_o(), .fault_i(fault_inject_i)
  );

  dmr_compare_recover i_compare (
    .clk_i, .rst_ni, .mode_i(mode), .res0_valid_i(res0_valid), .res1_valid_i(res1_valid),
    .res0_i(res0), .res1_i(res1), .pop_i(res0_valid && res0_ready), .acc0_i(acc0),
    .recovery_req_i(recovery_req), .sw_synch_req_i(sw_synch_req),
    .dmr_error_o(dmr_error), .cores_synch_o(cores_synch),
    .recovery_finished_o(recovery_fin), .load0_o(load0), .load1_o(load1),
    .load_val_o(load_val)
  );

  result_arbiter i_arbiter (
    .clk_i, .rst_ni, .mode_i(mode), .error_drop_i(error_drop),
    .in0_valid_i(res0_valid), .in1_valid_i(res1_valid), .in0_i(res0), .in1_i(res1),
    .in0_ready_o(res0_ready), .in1_ready_o(res1_ready),
    .out_valid_o(res_valid_o), .out_o(res_o), .out_ready_i(res_ready_i)
  );

endmodule

//--- sim/tb_dmr_lockstep.sv
// Testbench for the dual-core lockstep subsystem
// Runs independent, join, rollback, software and forced recovery phases with
// LFSR stimulus and compares every result and register read with a model
`timescale 1ns/1ns
`include "dmr_settings.svh"

module tb_dmr_lockstep import dmr_pkg::*; ();

  localparam int HALF_PERIOD    = 4;
  localparam int N_INDEP        = 60;
  localparam int N_LOCKSTEP     = 20;
  localparam int N_AFTER        = 10;
  localparam int TOTAL_OPS      = N_INDEP + N_LOCKSTEP + N_AFTER + 1 + 1 + N_AFTER;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_OPS + 200;

  logic      clk_i, rst_ni, fetch_en_i, fault_inject_i;
  logic      cfg_valid_i, cfg_ready_o, op_valid_i, op_ready_o, res_valid_o, res_ready_i;
  cfg_req_t  cfg_req_i;
  cfg_rsp_t  cfg_rsp_o;
  op_req_t   op_req_i;
  core_res_t res_o;

  // Model state written by the monitor only
  logic [`DMR_DATA_W-1:0] model_acc0 = '0;
  logic [`DMR_DATA_W-1:0] model_acc1 = '0;
  logic [`DMR_DATA_W-1:0] model_ckpt = '0;
  logic                   model_dmr = 1'b0;
  logic                   model_rapid = 1'b0;
  logic [15:0]            model_mm_cnt = '0;
  core_res_t              exp0_q[$];
  core_res_t              exp1_q[$];
  int accepted_cnt = 0;
  int res_checks = 0;
  int res_errors = 0;

  // Driver state
  logic [31:0] lfsr_q;
  logic        bp_en;
  int reg_checks = 0;
  int reg_errors = 0;
  int cycle_cnt = 0;

  dmr_lockstep i_dmr_lockstep (.*);

  initial begin
    clk_i = 1'b0;
    forever #HALF_PERIOD clk_i = ~clk_i;
  end

  // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      v      = {v[30:0], lfsr_q[31]};
      lfsr_q = {lfsr_q[30:0], fb};
    end
    return v;
  endfunction

  // Expected accumulator after one operation
  function automatic logic [`DMR_DATA_W-1:0] ref_acc(op_code_e op,
      logic [`DMR_DATA_W-1:0] acc, logic [`DMR_DATA_W-1:0] operand);
    if (op == OP_CLR) return '0;
    if (op == OP_XOR) return acc ^ operand;
    return acc + operand;
  endfunction

  function automatic op_req_t random_op();
    op_req_t     op;
    logic [31:0] r;
    r = rand_bits(2);
    // Unused code 3 folds onto add
    op.op = (r[1:0] == 2'd3) ? OP_ADD : op_code_e'(r[1:0]);
    r = rand_bits(1);
    op.core_id = r[0];
    r = rand_bits(`DMR_DATA_W);
    op.operand = r[`DMR_DATA_W-1:0];
    return op;
  endfunction

  task automatic check_res(core_res_t got, core_res_t exp);
    res_checks++;
    if (got !== exp) begin
      res_errors++;
      $display("[FAIL] %0t res_o got core=%0d acc=%h mm=%0b expected core=%0d acc=%h mm=%0b",
               $time, got.core_id, got.acc, got.mismatch, exp.core_id, exp.acc, exp.mismatch);
    end
  endtask

  task automatic check_rd(string name, cfg_rsp_t got, cfg_rsp_t exp);
    reg_checks++;
    if (got !== exp) begin
      reg_errors++;
      $display("[FAIL] %0t cfg_rsp_o %s got %h expected %h", $time, name, got.rdata, exp.rdata);
    end
  endtask

  task automatic check_mode(dmr_mode_e got, dmr_mode_e exp);
    reg_checks++;
    if (got !== exp) begin
      reg_errors++;
      $display("[FAIL] %0t mode got %s expected %s", $time, got.name(), exp.name());
    end
  endtask

  // Register writes seen on the bus steer the model
  task automatic model_cfg_write(cfg_req_t req);
    if (req.addr == `DMR_ADDR_CTRL) begin
      if (req.wdata[0] && !model_dmr) begin
        // Joining sets core 1 back to core 0
        model_acc1 = model_acc0;
        model_ckpt = model_acc0;
      end else if (req.wdata[0] && req.wdata[1] && req.wdata[2] && model_dmr) begin
        // Forced rollback of both copies
        model_acc0 = model_ckpt;
        model_acc1 = model_ckpt;
      end
      model_dmr   = req.wdata[0];
      model_rapid = req.wdata[1] && (`DMR_RAPID_RECOVERY != 0);
    end
  endtask

  task automatic model_accept(op_req_t op);
    logic [`DMR_DATA_W-1:0] n0, n1;
    core_res_t              exp;
    n0  = ref_acc(op.op, model_acc0, op.operand);
    n1  = ref_acc(op.op, model_acc1, op.operand);
    exp = '{core_id: 1'b0, acc: n0, mismatch: 1'b0};
    if (!model_dmr) begin
      if (op.core_id) begin
        model_acc1 = n1;
        exp1_q.push_back('{core_id: 1'b1, acc: n1, mismatch: 1'b0});
      end else begin
        model_acc0 = n0;
        exp0_q.push_back(exp);
      end
    end else if (n0 == n1) begin
      model_acc0 = n0;
      model_acc1 = n1;
      model_ckpt = n0;
      exp0_q.push_back(exp);
    end else if (model_rapid) begin
      // Dropped pair puts both copies back at the checkpoint
      model_acc0 = model_ckpt;
      model_acc1 = model_ckpt;
    end else begin
      model_acc0   = n0;
      model_acc1   = n1;
      exp.mismatch = 1'b1;
      exp0_q.push_back(exp);
      model_mm_cnt++;
    end
    accepted_cnt++;
  endtask

  task automatic compare_result(core_res_t got);
    if (!got.core_id && exp0_q.size() != 0) begin
      check_res(got, exp0_q.pop_front());
    end else if (got.core_id && exp1_q.size() != 0) begin
      check_res(got, exp1_q.pop_front());
    end else begin
      res_errors++;
      $display("%0t: result from core %0d arrived with no operation outstanding",
               $time, got.core_id);
    end
  endtask

  // Handshakes are sampled on the rising edge, inputs only move on the falling one
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (cfg_valid_i && !cfg_ready_o) begin
        reg_errors++;
        $display("%0t: configuration request was not accepted", $time);
      end
      if (cfg_valid_i && cfg_ready_o && cfg_req_i.write) model_cfg_write(cfg_req_i);
      // Upset lands on core 1 before any op of the same cycle
      if (fault_inject_i) model_acc1 = model_acc1 ^ `DMR_DATA_W'(1);
      if (op_valid_i && op_ready_o) model_accept(op_req_i);
      if (res_valid_o && res_ready_i) compare_result(res_o);
    end
  end

  task automatic next_cycle();
    logic [31:0] r;
    @(negedge clk_i);
    if (bp_en) begin
      r = rand_bits(1);
      res_ready_i = r[0];
    end
  endtask

  task automatic issue_op(op_req_t op);
    int target;
    target     = accepted_cnt + 1;
    op_valid_i = 1'b1;
    op_req_i   = op;
    while (accepted_cnt < target) begin
      next_cycle();
    end
    op_valid_i = 1'b0;
  endtask

  task automatic drain();
    bp_en       = 1'b0;
    res_ready_i = 1'b1;
    while (exp0_q.size() != 0 || exp1_q.size() != 0) begin
      next_cycle();
    end
    next_cycle();
  endtask

  task automatic inject_fault();
    fault_inject_i = 1'b1;
    next_cycle();
    fault_inject_i = 1'b0;
  endtask

  task automatic cfg_write(logic [1:0] addr, logic [15:0] data);
    cfg_valid_i = 1'b1;
    cfg_req_i   = '{write: 1'b1, addr: addr, wdata: data};
    next_cycle();
    cfg_valid_i     = 1'b0;
    cfg_req_i.write = 1'b0;
  endtask

  // Read data is combinational, taken after a full cycle on the bus
  task automatic cfg_read(logic [1:0] addr, output cfg_rsp_t rsp);
    cfg_valid_i = 1'b1;
    cfg_req_i   = '{write: 1'b0, addr: addr, wdata: 16'h0000};
    next_cycle();
    rsp         = cfg_rsp_o;
    cfg_valid_i = 1'b0;
  endtask

  task automatic expect_reg(logic [1:0] addr, logic [15:0] value, string name);
    cfg_rsp_t rsp;
    cfg_read(addr, rsp);
    check_rd(name, rsp, '{rdata: value});
  endtask

  task automatic wait_mode(dmr_mode_e exp);
    cfg_rsp_t rsp;
    int       tries;
    tries = 0;
    do begin
      cfg_read(`DMR_ADDR_STATUS, rsp);
      tries++;
    end while (dmr_mode_e'(rsp.rdata[1:0]) != exp && tries < 20);
    check_mode(dmr_mode_e'(rsp.rdata[1:0]), exp);
  endtask

  task automatic report_counts();
    $display("Result checks %0d, register checks %0d, errors %0d",
             res_checks, reg_checks, res_errors + reg_errors);
  endtask

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    report_counts();
    $display("Checks failed");
    $finish;
  end

  initial begin
    rst_ni         = 1'b0;
    fetch_en_i     = 1'b0;
    fault_inject_i = 1'b0;
    cfg_valid_i    = 1'b0;
    cfg_req_i      = '0;
    op_valid_i     = 1'b0;
    op_req_i       = '0;
    res_ready_i    = 1'b1;
    lfsr_q         = 32'h972e_42ec;
    bp_en          = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni     = 1'b1;
    fetch_en_i = 1'b1;

    // Independent cores under random back-pressure
    bp_en = 1'b1;
    repeat (N_INDEP) issue_op(random_op());
    drain();

    // Register readback with rapid recovery on and the pair still split
    cfg_write(`DMR_ADDR_CTRL, 16'h0002);
    expect_reg(`DMR_ADDR_CTRL, 16'h0002, "CTRL");
    expect_reg(`DMR_ADDR_STATUS, 16'h0000, "STATUS");
    expect_reg(`DMR_ADDR_MISMATCH, 16'h0000, "MISMATCH");

    // Core 1 upset before the join so the setback must hide it
    inject_fault();
    cfg_write(`DMR_ADDR_CTRL, 16'h0003);
    wait_mode(DMR_RUN);
    bp_en = 1'b1;
    repeat (N_LOCKSTEP) issue_op(random_op());
    drain();

    // Rollback of a faulty pair
    inject_fault();
    issue_op('{op: OP_ADD, core_id: 1'b0, operand: `DMR_DATA_W'(rand_bits(`DMR_DATA_W))});
    bp_en = 1'b1;
    repeat (N_AFTER) issue_op(random_op());
    drain();
    expect_reg(`DMR_ADDR_MISMATCH, 16'h0000, "MISMATCH");
    expect_reg(`DMR_ADDR_STATUS, 16'h0001, "STATUS");

    // Without rapid recovery software gets the flag and the count
    cfg_write(`DMR_ADDR_CTRL, 16'h0001);
    inject_fault();
    issue_op('{op: OP_ADD, core_id: 1'b0, operand: `DMR_DATA_W'(rand_bits(`DMR_DATA_W))});
    drain();
    expect_reg(`DMR_ADDR_STATUS, 16'h0005, "STATUS");
    expect_reg(`DMR_ADDR_MISMATCH, 16'h0001, "MISMATCH");
    cfg_write(`DMR_ADDR_STATUS, 16'h0004);
    expect_reg(`DMR_ADDR_STATUS, 16'h0001, "STATUS");

    // Forced recovery brings both copies back to the checkpoint
    cfg_write(`DMR_ADDR_CTRL, 16'h0007);
    wait_mode(DMR_RUN);
    expect_reg(`DMR_ADDR_CTRL, 16'h0003, "CTRL");
    bp_en = 1'b1;
    repeat (N_AFTER) issue_op(random_op());
    drain();
    expect_reg(`DMR_ADDR_MISMATCH, model_mm_cnt, "MISMATCH");

    report_counts();
    if (res_errors == 0 && reg_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- dmr_lockstep.f
+incdir+include
source/dmr_pkg.sv
source/dmr_cfg_regs.sv
source/dmr_ctrl.sv
source/accum_core.sv
source/dmr_compare_recover.sv
source/result_arbiter.sv
source/dmr_lockstep.sv
sim/tb_dmr_lockstep.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the lockstep testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_dmr_lockstep -f dmr_lockstep.f &&
  ./obj_dir/Vtb_dmr_lockstep | tee sim.log
grep -qx "All checks passed" sim.log && echo "Simulation PASSED" ||
  { echo "Simulation FAILED"; exit 1; }
